/* source/tdc_settings.svh */
`ifndef TDC_SETTINGS_SVH
`define TDC_SETTINGS_SVH

// DLL taps and the fine code taken from them
`define TDC_PHASE_W   32
`define TDC_FINE_W    5

// coarse counter, one step per clk
`define TDC_COARSE_W  10
`define TDC_TOF_W     15   // coarse and fine side by side

// 4x4 pixel
`define TDC_SPAD_W    16
`define TDC_INT_W     4

`define TDC_MAX_HITS  3    // hits kept per window
`define TDC_NUM_W     2

// sent for a missing or out-of-range hit
`define TDC_NO_HIT    {`TDC_TOF_W{1'b1}}

`endif

/* source/tdc_pkg.sv */
`default_nettype none

`include "tdc_settings.svh"

package tdc_pkg;

    // ----------------------------------------
    // data words

    typedef logic [`TDC_PHASE_W-1:0]  phase_t;      // one bit per DLL tap
    typedef logic [`TDC_FINE_W-1:0]   fine_t;
    typedef logic [`TDC_COARSE_W-1:0] coarse_t;
    typedef logic [`TDC_TOF_W-1:0]    tof_t;        // time of flight, also the range
    typedef logic [`TDC_SPAD_W-1:0]   spad_mask_t;
    typedef logic [`TDC_INT_W-1:0]    intensity_t;
    typedef logic [`TDC_NUM_W-1:0]    hit_num_t;

    // ----------------------------------------
    // output FSM

    // DONE holds finished results until the sink is ready
    typedef enum logic [1:0] {
        IDLE,
        BEAT,
        DONE
    } burst_state_t;

endpackage

`default_nettype wire

/* source/tdc_window.sv */
`default_nettype none

`include "tdc_settings.svh"

module tdc_window (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start_i,
    input  wire tdc_pkg::phase_t phase_i,
    input  wire tdc_pkg::tof_t   range_i,
    input  wire                  busy_i,
    output logic                 window_open_o,
    output logic                 window_close_o,
    output tdc_pkg::coarse_t     coarse_o,
    output tdc_pkg::phase_t      start_phase_o,
    output tdc_pkg::tof_t        range_o,
    output logic                 start_accept_o
);

    logic at_limit;

    // coarse steps are 32 fine steps, so the upper range bits set the length
    assign at_limit = coarse_o == range_o[`TDC_TOF_W-1:`TDC_FINE_W];

    // a start while measuring or sending is dropped
    assign start_accept_o = start_i & ~window_open_o & ~busy_i;

    // last open cycle where a trigger still counts
    assign window_close_o = window_open_o & at_limit;

    // ----------------------------------------
    // window and coarse counter

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_open_o <= 1'b0;
            coarse_o      <= '0;
        end else if (start_accept_o) begin
            window_open_o <= 1'b1;
            coarse_o      <= '0;
        end else if (window_close_o) begin
            window_open_o <= 1'b0;           // count holds for the results
        end else if (window_open_o) begin
            coarse_o <= coarse_o + 1'b1;
        end
    end

    // start phase and range held until the next start
    always_ff @(posedge clk) begin
        if (start_accept_o) begin
            start_phase_o <= phase_i;
            range_o       <= range_i;
        end
    end

    // the burst stage holds off starts from the close on
    assert property (@(posedge clk) disable iff (!rst_n)
        window_close_o |=> busy_i);

endmodule

`default_nettype wire

/* source/tdc_hit_capture.sv */
`default_nettype none

`include "tdc_settings.svh"

module tdc_hit_capture (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start_accept_i,
    input  wire                      window_open_i,
    input  wire                      trigger_i,
    input  wire tdc_pkg::coarse_t    coarse_i,
    input  wire tdc_pkg::phase_t     phase_i,
    input  wire tdc_pkg::spad_mask_t spad_i,
    output tdc_pkg::hit_num_t        hit_num_o,
    output tdc_pkg::coarse_t         hit_coarse_o [`TDC_MAX_HITS],
    output tdc_pkg::phase_t          hit_phase_o  [`TDC_MAX_HITS],
    output tdc_pkg::spad_mask_t      hit_mask_o   [`TDC_MAX_HITS]
);
    import tdc_pkg::*;

    logic full;
    logic take_hit;

    assign full     = hit_num_o == hit_num_t'(`TDC_MAX_HITS);
    assign take_hit = trigger_i & window_open_i & ~full;   // later triggers dropped

    // ----------------------------------------
    // hit count

    // start and take_hit never meet since a start needs the window shut
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_num_o <= '0;
        end else if (start_accept_i) begin
            hit_num_o <= '0;
        end else if (take_hit) begin
            hit_num_o <= hit_num_o + 1'b1;
        end
    end

    // ----------------------------------------
    // hit store

    // entries past hit_num_o are stale and never read
    always_ff @(posedge clk) begin
        if (take_hit) begin
            hit_coarse_o[hit_num_o] <= coarse_i;
            hit_phase_o[hit_num_o]  <= phase_i;   // DLL taps at the stop
            hit_mask_o[hit_num_o]   <= spad_i;
        end
    end

    // hits are stored in arrival order
    assert property (@(posedge clk) disable iff (!rst_n)
        take_hit && hit_num_o != '0 |-> coarse_i > hit_coarse_o[hit_num_o - 1'b1]);

endmodule

`default_nettype wire

/* source/tdc_calc.sv */
`default_nettype none

`include "tdc_settings.svh"

module tdc_calc (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      window_close_i,
    input  wire tdc_pkg::hit_num_t   hit_num_i,
    input  wire tdc_pkg::coarse_t    hit_coarse_i [`TDC_MAX_HITS],
    input  wire tdc_pkg::phase_t     hit_phase_i  [`TDC_MAX_HITS],
    input  wire tdc_pkg::spad_mask_t hit_mask_i   [`TDC_MAX_HITS],
    input  wire tdc_pkg::phase_t     start_phase_i,
    input  wire tdc_pkg::tof_t       range_i,
    output tdc_pkg::tof_t            tof_res_o [`TDC_MAX_HITS],
    output tdc_pkg::intensity_t      int_res_o [`TDC_MAX_HITS],
    output logic                     results_valid_o
);
    import tdc_pkg::*;

    typedef logic [$clog2(`TDC_PHASE_W+1)-1:0] ones_t;

    logic                active_q;
    hit_num_t            idx_q;         // hit being processed
    logic                have_hit;
    logic                last_hit;
    ones_t               start_ones;
    ones_t               stop_ones;
    ones_t               mask_ones;
    fine_t               start_fine;
    fine_t               stop_fine;
    logic [`TDC_TOF_W:0] tof_wide;      // top bit set when the stop is ahead of the start
    tof_t                tof_val;
    intensity_t          int_val;

    // number of set bits, masks come in zero extended
    function automatic ones_t ones_count(input phase_t bits);
        ones_t n;
        n = '0;
        for (int i = 0; i < `TDC_PHASE_W; i++) begin
            n = n + ones_t'(bits[i]);
        end
        return n;
    endfunction

    // ----------------------------------------
    // decode of the current hit

    assign start_ones = ones_count(start_phase_i);
    assign stop_ones  = ones_count(hit_phase_i[idx_q]);
    assign mask_ones  = ones_count(phase_t'(hit_mask_i[idx_q]));

    // all 32 taps high still reads as 31
    assign start_fine = (start_ones > ones_t'(fine_t'('1))) ? '1 : fine_t'(start_ones);
    assign stop_fine  = (stop_ones > ones_t'(fine_t'('1))) ? '1 : fine_t'(stop_ones);
    assign int_val    = (mask_ones > ones_t'(intensity_t'('1))) ? '1 : intensity_t'(mask_ones);

    assign tof_wide = {1'b0, hit_coarse_i[idx_q], {`TDC_FINE_W{1'b0}}}
                      + stop_fine - start_fine;

    assign tof_val = (tof_wide[`TDC_TOF_W] || tof_wide[`TDC_TOF_W-1:0] > range_i)
                     ? `TDC_NO_HIT : tof_wide[`TDC_TOF_W-1:0];

    // ----------------------------------------
    // sequencing

    assign have_hit = idx_q < hit_num_i;
    assign last_hit = hit_num_i == '0 || idx_q == hit_num_i - 1'b1;

    // starts a cycle after close so a trigger on the closing cycle is in hit_num_i
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q        <= 1'b0;
            idx_q           <= '0;
            results_valid_o <= 1'b0;
        end else begin
            results_valid_o <= 1'b0;
            if (window_close_i) begin
                active_q <= 1'b1;
                idx_q    <= '0;
            end else if (active_q) begin
                if (last_hit) begin
                    active_q        <= 1'b0;
                    results_valid_o <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active_q && have_hit) begin
            tof_res_o[idx_q] <= tof_val;
            int_res_o[idx_q] <= int_val;
        end
    end

endmodule

`default_nettype wire

/* source/tdc_burst_out.sv */
`default_nettype none

`include "tdc_settings.svh"

module tdc_burst_out (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      window_close_i,
    input  wire                      results_valid_i,
    input  wire tdc_pkg::hit_num_t   hit_num_i,
    input  wire tdc_pkg::tof_t       tof_res_i [`TDC_MAX_HITS],
    input  wire tdc_pkg::intensity_t int_res_i [`TDC_MAX_HITS],
    input  wire                      ready_i,
    output logic                     busy_o,
    output tdc_pkg::tof_t            tof_o,
    output tdc_pkg::intensity_t      int_o,
    output tdc_pkg::hit_num_t        num_o,
    output logic                     last_o,
    output logic                     valid_o
);
    import tdc_pkg::*;

    burst_state_t state_q;
    burst_state_t state_d;
    hit_num_t     beat_q;
    hit_num_t     last_beat;
    logic         no_hits;

    assign no_hits   = hit_num_i == '0;
    assign last_beat = no_hits ? '0 : hit_num_i - 1'b1;   // marker burst is one beat

    // ----------------------------------------
    // next state

    // ready_i only matters before the first beat
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (results_valid_i) begin
                    state_d = ready_i ? BEAT : DONE;
                end
            end
            DONE: begin
                if (ready_i) begin
                    state_d = BEAT;
                end
            end
            BEAT: begin
                if (beat_q == last_beat) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            beat_q  <= '0;
            busy_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == BEAT) begin
                beat_q <= last_o ? '0 : beat_q + 1'b1;
            end
            if (window_close_i) begin
                busy_o <= 1'b1;              // holds off starts until the burst is out
            end else if (last_o) begin
                busy_o <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // output beats

    assign valid_o = state_q == BEAT;
    assign last_o  = valid_o && beat_q == last_beat;
    assign num_o   = valid_o ? hit_num_i : '0;

    always_comb begin
        tof_o = '0;
        int_o = '0;
        if (valid_o) begin
            if (no_hits) begin
                tof_o = `TDC_NO_HIT;         // intensity stays 0
            end else begin
                tof_o = tof_res_i[beat_q];
                int_o = int_res_i[beat_q];
            end
        end
    end

    // results only arrive between bursts while starts are held off
    assert property (@(posedge clk) disable iff (!rst_n)
        results_valid_i |-> state_q == IDLE && busy_o);

endmodule

`default_nettype wire

/* source/tdc_top.sv */
`default_nettype none

`include "tdc_settings.svh"

module tdc_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire tdc_pkg::phase_t     phase_i,     // DLL taps
    input  wire                      start_i,
    input  wire                      trigger_i,   // SPAD
    input  wire tdc_pkg::spad_mask_t spad_i,
    input  wire tdc_pkg::tof_t       range_i,
    input  wire                      ready_i,
    output wire tdc_pkg::tof_t       tof_o,
    output wire tdc_pkg::intensity_t int_o,
    output wire tdc_pkg::hit_num_t   num_o,
    output wire                      last_o,
    output wire                      valid_o
);
    import tdc_pkg::*;

    // ----------------------------------------
    // stage links

    wire             window_open;
    wire             window_close;
    wire             start_accept;
    wire coarse_t    coarse;
    wire phase_t     start_phase;
    wire tof_t       range_q;
    wire             busy;

    wire hit_num_t   hit_num;
    wire coarse_t    hit_coarse [`TDC_MAX_HITS];
    wire phase_t     hit_phase  [`TDC_MAX_HITS];
    wire spad_mask_t hit_mask   [`TDC_MAX_HITS];

    wire tof_t       tof_res [`TDC_MAX_HITS];
    wire intensity_t int_res [`TDC_MAX_HITS];
    wire             results_valid;

    // ----------------------------------------
    // pipeline

    tdc_window u_window (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .phase_i        (phase_i),
        .range_i        (range_i),
        .busy_i         (busy),
        .window_open_o  (window_open),
        .window_close_o (window_close),
        .coarse_o       (coarse),
        .start_phase_o  (start_phase),
        .range_o        (range_q),
        .start_accept_o (start_accept)
    );

    tdc_hit_capture u_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_accept_i (start_accept),
        .window_open_i  (window_open),
        .trigger_i      (trigger_i),
        .coarse_i       (coarse),
        .phase_i        (phase_i),        // stop phase, same DLL taps
        .spad_i         (spad_i),
        .hit_num_o      (hit_num),
        .hit_coarse_o   (hit_coarse),
        .hit_phase_o    (hit_phase),
        .hit_mask_o     (hit_mask)
    );

    tdc_calc u_calc (
        .clk             (clk),
        .rst_n           (rst_n),
        .window_close_i  (window_close),
        .hit_num_i       (hit_num),
        .hit_coarse_i    (hit_coarse),
        .hit_phase_i     (hit_phase),
        .hit_mask_i      (hit_mask),
        .start_phase_i   (start_phase),
        .range_i         (range_q),
        .tof_res_o       (tof_res),
        .int_res_o       (int_res),
        .results_valid_o (results_valid)
    );

    tdc_burst_out u_burst (
        .clk             (clk),
        .rst_n           (rst_n),
        .window_close_i  (window_close),
        .results_valid_i (results_valid),
        .hit_num_i       (hit_num),
        .tof_res_i       (tof_res),
        .int_res_i       (int_res),
        .ready_i         (ready_i),
        .busy_o          (busy),
        .tof_o           (tof_o),
        .int_o           (int_o),
        .num_o           (num_o),
        .last_o          (last_o),
        .valid_o         (valid_o)
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // held low over 5 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/tb_checker.sv */
`default_nettype none

module tb_checker (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      valid_i,
    input  wire                      last_i,
    input  wire tdc_pkg::tof_t       tof_i,
    input  wire tdc_pkg::intensity_t int_i,
    input  wire tdc_pkg::hit_num_t   num_i,
    input  wire                      ready_i,
    input  wire logic [31:0]         exp_bursts_i,
    input  wire tdc_pkg::hit_num_t   exp_num_i,
    input  wire tdc_pkg::tof_t       exp_tof_i [3],
    input  wire tdc_pkg::intensity_t exp_int_i [3],
    output int                       bursts_o,
    output int                       errors_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import tdc_pkg::*;

    int   burst_cnt = 0;
    int   err_cnt   = 0;
    int   beat      = 0;      // position in the running burst
    logic ready_q   = 1'b0;   // ready_i one clock back

    assign bursts_o = burst_cnt;
    assign errors_o = err_cnt;

    task automatic mismatch(input string what, input int got, input int want);
        $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        err_cnt++;
    endtask

    task automatic protocol_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    // ----------------------------------------
    // one beat on the output ports

    task automatic check_beat();
        int n;
        n = (exp_num_i == '0) ? 1 : int'(exp_num_i);   // marker burst is one beat
        if (beat == 0) begin
            if (burst_cnt >= int'(exp_bursts_i)) begin
                protocol_error("a burst came out that no accepted start asked for");
            end
            if (!ready_q) begin
                protocol_error("first beat came out while ready_i was low");
            end
        end
        if (beat >= n) begin
            protocol_error("burst is longer than the expected hit count");
        end else begin
            if (tof_i != exp_tof_i[beat]) begin
                mismatch($sformatf("tof_o on beat %0d", beat), int'(tof_i),
                         int'(exp_tof_i[beat]));
            end
            if (int_i != exp_int_i[beat]) begin
                mismatch($sformatf("int_o on beat %0d", beat), int'(int_i),
                         int'(exp_int_i[beat]));
            end
            if (last_i != (beat == n - 1)) begin
                mismatch($sformatf("last_o on beat %0d", beat), int'(last_i),
                         int'(beat == n - 1));
            end
        end
        if (num_i != exp_num_i) begin
            mismatch("num_o", int'(num_i), int'(exp_num_i));
        end
        if (last_i) begin
            burst_cnt++;
            beat = 0;
        end else begin
            beat++;
        end
    endtask

    // ----------------------------------------
    // sampled on the rising edge, inputs move on the falling one

    always @(posedge clk) begin
        if (rst_n) begin
            if (valid_i) begin
                check_beat();
            end else begin
                if (beat != 0) begin
                    protocol_error("burst stopped before its last beat");
                    beat = 0;
                end
                if (last_i) begin
                    protocol_error("last_o high outside a beat");
                end
                if (tof_i != '0 || int_i != '0) begin
                    protocol_error("tof_o or int_o not zero between beats");
                end
            end
        end
        ready_q = ready_i;
    end

endmodule

`default_nettype wire

/* tests/tb_top.sv */
`default_nettype none

`include "tdc_settings.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import tdc_pkg::*;

    localparam int NUM_TESTS     = 7;
    localparam int SLOTS         = 5;
    localparam int BURST_TIMEOUT = 100;   // cycles
    localparam int RESET_TIMEOUT = 20;

    wire        clk;
    wire        rst_n;
    logic       start_i;
    logic       trigger_i;
    logic       ready_i;
    phase_t     phase_i;
    spad_mask_t spad_i;
    tof_t       range_i;
    wire tof_t       tof_o;
    wire intensity_t int_o;
    wire hit_num_t   num_o;
    wire             last_o;
    wire             valid_o;

    // expected burst for the checker
    int         exp_bursts;
    hit_num_t   exp_num;
    tof_t       exp_tof [3];
    intensity_t exp_int [3];
    int         bursts_seen;
    int         errors;

    logic [31:0] lfsr_q = 32'h3654_8f24;
    int          wait_cnt;
    bit          timed_out;
    int          tests_ok;

    // ----------------------------------------
    // stimulus table with one entry per test
    // offsets count cycles from the start strobe and 0 marks an unused slot

    string       t_name  [NUM_TESTS] = '{"one hit", "five triggers", "no hits", "range limit",
                                         "saturation", "ready held low", "closing cycle"};
    int          t_range [NUM_TESTS] = '{400, 600, 200, 100, 1000, 300, 160};
    int          t_off   [NUM_TESTS][SLOTS] = '{'{5, 0, 0, 0, 0}, '{2, 4, 7, 9, 12},
                                                '{0, 0, 0, 0, 0}, '{2, 4, 0, 0, 0},
                                                '{3, 6, 0, 0, 0}, '{3, 8, 0, 0, 0},
                                                '{6, 7, 0, 0, 0}};
    bit          t_fixed [NUM_TESTS] = '{0, 0, 0, 1, 1, 0, 0};   // 0 takes phases from the LFSR
    logic [31:0] t_start [NUM_TESTS] = '{0, 0, 0, 32'h0000_000f, 32'h0000_0003, 0, 0};
    logic [31:0] t_stop  [NUM_TESTS][SLOTS] = '{'{0, 0, 0, 0, 0}, '{0, 0, 0, 0, 0},
                                                '{0, 0, 0, 0, 0},
                                                '{32'h0000_00ff, 32'h0000_ffff, 0, 0, 0},
                                                '{32'hffff_ffff, 32'hffff_fffe, 0, 0, 0},
                                                '{0, 0, 0, 0, 0}, '{0, 0, 0, 0, 0}};
    logic [15:0] t_mask  [NUM_TESTS][SLOTS] = '{'{0, 0, 0, 0, 0}, '{0, 0, 0, 0, 0},
                                                '{0, 0, 0, 0, 0},
                                                '{16'h00f0, 16'h0001, 0, 0, 0},
                                                '{16'hffff, 16'h00ff, 0, 0, 0},
                                                '{0, 0, 0, 0, 0}, '{0, 0, 0, 0, 0}};
    int          t_delay [NUM_TESTS] = '{0, 0, 0, 0, 0, 10, 0};   // ready_i low cycles

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tdc_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase_i   (phase_i),
        .start_i   (start_i),
        .trigger_i (trigger_i),
        .spad_i    (spad_i),
        .range_i   (range_i),
        .ready_i   (ready_i),
        .tof_o     (tof_o),
        .int_o     (int_o),
        .num_o     (num_o),
        .last_o    (last_o),
        .valid_o   (valid_o)
    );

    tb_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_o),
        .last_i       (last_o),
        .tof_i        (tof_o),
        .int_i        (int_o),
        .num_i        (num_o),
        .ready_i      (ready_i),
        .exp_bursts_i (exp_bursts),
        .exp_num_i    (exp_num),
        .exp_tof_i    (exp_tof),
        .exp_int_i    (exp_int),
        .bursts_o     (bursts_seen),
        .errors_o     (errors)
    );

    // ----------------------------------------
    // random bits and the reference model

    // galois form stepped once per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    function automatic int ones(input logic [31:0] w);
        int c;
        c = 0;
        for (int i = 0; i < 32; i++) begin
            c = c + int'(w[i]);
        end
        return c;
    endfunction

    function automatic int fine_code(input logic [31:0] ph);
        return (ones(ph) > 31) ? 31 : ones(ph);   // 32 taps still read 31
    endfunction

    function automatic int intensity(input logic [15:0] mask);
        return (ones({16'h0, mask}) > 15) ? 15 : ones({16'h0, mask});
    endfunction

    // ----------------------------------------
    // one table entry

    task automatic run_test(input int t, output bit ok);
        logic [31:0] start_ph;
        logic [31:0] stop_ph [SLOTS];
        logic [15:0] mask [SLOTS];
        int          limit;
        int          last_cycle;
        int          n;
        int          tof;
        int          cnt;
        limit    = t_range[t] >> 5;   // last coarse count inside the window
        start_ph = t_fixed[t] ? t_start[t] : random_bits(32);
        for (int s = 0; s < SLOTS; s++) begin
            stop_ph[s] = t_fixed[t] ? t_stop[t][s] : random_bits(32);
            mask[s]    = t_fixed[t] ? t_mask[t][s] : 16'(random_bits(16));
        end

        // trigger at offset k sees coarse count k-1
        n = 0;
        for (int s = 0; s < SLOTS; s++) begin
            if (t_off[t][s] >= 1 && t_off[t][s] <= limit + 1 && n < 3) begin
                tof = (t_off[t][s] - 1) * 32 + fine_code(stop_ph[s]) - fine_code(start_ph);
                exp_tof[n] = (tof < 0 || tof > t_range[t]) ? `TDC_NO_HIT : tof_t'(tof);
                exp_int[n] = intensity_t'(intensity(mask[s]));
                n++;
            end
        end
        if (n == 0) begin
            exp_tof[0] = `TDC_NO_HIT;
            exp_int[0] = '0;
        end
        exp_num    = hit_num_t'(n);
        exp_bursts = exp_bursts + 1;

        @(negedge clk);
        start_i = 1'b1;
        phase_i = start_ph;
        range_i = tof_t'(t_range[t]);
        ready_i = (t_delay[t] == 0);
        last_cycle = limit + 4;
        for (int s = 0; s < SLOTS; s++) begin
            if (t_off[t][s] > last_cycle) begin
                last_cycle = t_off[t][s];
            end
        end
        for (int k = 1; k <= last_cycle; k++) begin
            @(negedge clk);
            start_i   = 1'b0;
            trigger_i = 1'b0;
            phase_i   = '0;
            spad_i    = '0;
            for (int s = 0; s < SLOTS; s++) begin
                if (t_off[t][s] == k) begin
                    trigger_i = 1'b1;
                    phase_i   = stop_ph[s];
                    spad_i    = mask[s];
                end
            end
            if (t_delay[t] != 0 && k == limit + 3) begin
                start_i = 1'b1;   // window shut with the burst pending
                phase_i = random_bits(32);
            end
        end
        @(negedge clk);
        start_i   = 1'b0;
        trigger_i = 1'b0;
        phase_i   = '0;
        spad_i    = '0;
        if (t_delay[t] != 0) begin
            repeat (t_delay[t]) @(negedge clk);
            ready_i = 1'b1;
        end

        cnt = 0;
        while (bursts_seen < exp_bursts && cnt < BURST_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        ok = bursts_seen >= exp_bursts;
        if (!ok) begin
            $display("timed out after %0d cycles waiting for the burst of test %0d", cnt, t);
        end
        repeat (3) @(negedge clk);   // room for a stray beat
    endtask

    // ----------------------------------------
    // main sequence

    initial begin
        start_i    = 1'b0;
        trigger_i  = 1'b0;
        ready_i    = 1'b1;
        phase_i    = '0;
        spad_i     = '0;
        range_i    = '0;
        exp_bursts = 0;
        exp_num    = '0;
        foreach (exp_tof[i]) begin
            exp_tof[i] = '0;
            exp_int[i] = '0;
        end
        timed_out = 1'b0;
        tests_ok  = 0;

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            timed_out = 1'b1;
        end

        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            int err_before;
            bit ok;
            err_before = errors;
            run_test(t, ok);
            if (!ok) begin
                timed_out = 1'b1;
            end
            if (ok && errors == err_before) begin
                tests_ok++;
            end
            $display("test %0d %s: %s", t, t_name[t],
                     (ok && errors == err_before) ? "ok" : "FAILED");
        end

        repeat (10) @(negedge clk);   // nothing may come out after the last test
        $display("tests %0d, passed %0d, errors %0d", NUM_TESTS, tests_ok, errors);
        if (timed_out || errors != 0 || tests_ok != NUM_TESTS) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/tdc_pkg.sv
source/tdc_window.sv
source/tdc_hit_capture.sv
source/tdc_calc.sv
source/tdc_burst_out.sv
source/tdc_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TDC testbench with Verilator.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tdc_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f verilog.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $LOG"
    exit 1
fi
